// ==== design/lsq_config.svh ====
// sizing values for the load/store queue and data memory, included by every design file
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// number of queue entries
`define LSQ_DEPTH 16

// tag width, one tag per queue slot
`define LSQ_TAG_W 4

// address and data word width
`define DATA_W 32

// data memory size in words
// word index is taken from address bits 11:2
`define MEM_WORDS 1024

// depth of the slow (even index) delay line
`define MEM_SLOW_STAGES 3

`endif

// ==== design/lsqPkg.sv ====
// queue-side types shared by the load/store queue, the memory port and the memory answers
`default_nettype none

`include "lsq_config.svh"

package lsqPkg;

  // slot index, also used as the memory request tag
  typedef logic [`LSQ_TAG_W-1:0] tagT;

  // destination register field from the core
  typedef logic [3:0] destT;

  // one ring entry
  typedef struct packed {
    // store when set, load otherwise
    logic isWrite;
    // sent to memory
    logic issued;
    // memory answered
    logic done;
    logic [`DATA_W-1:0] addr;
    // store data on entry, load data once answered
    logic [`DATA_W-1:0] data;
    destT dest;
  } entryT;

endpackage

`default_nettype wire

// ==== design/memPkg.sv ====
// memory-side types for the word array index and the tagged answer leaving the memory
`default_nettype none

`include "lsq_config.svh"

package memPkg;

  // word index into the data array
  typedef logic [$clog2(`MEM_WORDS)-1:0] wordIdxT;

  // one answer travelling through the fast or slow path
  typedef struct packed {
    logic valid;
    // queue slot the answer belongs to
    lsqPkg::tagT tag;
    // read data, zero for a store
    logic [`DATA_W-1:0] data;
  } memRspT;

endpackage

`default_nettype wire

// ==== design/memPortIf.sv ====
// request/response channel between the load/store queue and the data memory
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

interface memPortIf;

  // request, driven by the queue
  logic reqValid;
  logic reqWrite;
  lsqPkg::tagT reqTag;
  logic [`DATA_W-1:0] reqAddr;
  logic [`DATA_W-1:0] reqData;

  // memory takes the request on an edge where this is high too
  logic reqReady;

  // answer, a one cycle pulse that cannot be refused
  logic rspValid;
  lsqPkg::tagT rspTag;
  logic [`DATA_W-1:0] rspData;

  modport lsqSide (
    output reqValid, reqWrite, reqTag, reqAddr, reqData,
    input  reqReady, rspValid, rspTag, rspData
  );

  modport memSide (
    input  reqValid, reqWrite, reqTag, reqAddr, reqData,
    output reqReady, rspValid, rspTag, rspData
  );

endinterface

`default_nettype wire

// ==== design/loadStoreQueue.sv ====
// in-order load/store queue, issues to memory in program order and retires oldest-first
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module loadStoreQueue (
  input  wire                      clk,
  input  wire                      rst,
  // core request side
  input  wire                      i_reqValid,
  input  wire                      i_reqWrite,
  input  wire  [`DATA_W-1:0]       i_reqAddr,
  input  wire  [`DATA_W-1:0]       i_reqData,
  input  wire  lsqPkg::destT       i_reqDest,
  output logic                     o_reqStall,
  output logic                     o_empty,
  // core retire side
  output logic                     o_retValid,
  output logic                     o_retWrite,
  output logic [`DATA_W-1:0]       o_retAddr,
  output logic [`DATA_W-1:0]       o_retData,
  output lsqPkg::destT             o_retDest,
  // memory side
  memPortIf.lsqSide                mem
);

  localparam int cntW = $clog2(`LSQ_DEPTH + 1);

  // ring storage, payload only, guarded by the count
  lsqPkg::entryT entries [`LSQ_DEPTH];

  // oldest entry, oldest unissued entry, next free slot
  lsqPkg::tagT headPtr;
  lsqPkg::tagT issuePtr;
  lsqPkg::tagT tailPtr;
  logic [cntW-1:0] count;
  logic [cntW-1:0] nextCount;

  logic accept;
  logic issuePending;
  logic issueFire;
  logic retire;
  lsqPkg::entryT allocEntry;

  // ring pointer step, wraps at the queue depth
  function automatic lsqPkg::tagT nextPtr(input lsqPkg::tagT ptr);
    if (ptr == lsqPkg::tagT'(`LSQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // core handshake, stall is already registered from the count
  assign accept = i_reqValid && !o_reqStall;

  // head is ready to leave once memory has answered it
  assign retire = (count != '0) && entries[headPtr].done;

  // issue pointer trails the tail while anything is unissued
  // when full the pointers meet, so look at the flag instead
  assign issuePending = (issuePtr != tailPtr) ||
                        ((count == cntW'(`LSQ_DEPTH)) && !entries[issuePtr].issued);

  assign issueFire = mem.reqValid && mem.reqReady;

  // oldest unissued entry drives the request, tagged by its slot
  assign mem.reqValid = issuePending;
  assign mem.reqWrite = entries[issuePtr].isWrite;
  assign mem.reqTag   = issuePtr;
  assign mem.reqAddr  = entries[issuePtr].addr;
  assign mem.reqData  = entries[issuePtr].data;

  // fresh entry built from the core request
  always_comb begin
    allocEntry.isWrite = i_reqWrite;
    allocEntry.issued  = 1'b0;
    allocEntry.done    = 1'b0;
    allocEntry.addr    = i_reqAddr;
    allocEntry.data    = i_reqData;
    allocEntry.dest    = i_reqDest;
  end

  // occupancy after this edge
  always_comb begin
    nextCount = count;
    if (accept) begin
      nextCount = nextCount + cntW'(1);
    end
    if (retire) begin
      nextCount = nextCount - cntW'(1);
    end
  end

  // pointers, count, flags toward the core
  always_ff @(posedge clk) begin
    if (rst) begin
      headPtr    <= '0;
      issuePtr   <= '0;
      tailPtr    <= '0;
      count      <= '0;
      o_reqStall <= 1'b0;
      o_empty    <= 1'b1;
      o_retValid <= 1'b0;
    end else begin
      if (accept) begin
        tailPtr <= nextPtr(tailPtr);
      end
      if (issueFire) begin
        issuePtr <= nextPtr(issuePtr);
      end
      if (retire) begin
        headPtr <= nextPtr(headPtr);
      end
      // one cycle pulse per retired entry
      o_retValid <= retire;
      count      <= nextCount;
      o_reqStall <= (nextCount == cntW'(`LSQ_DEPTH));
      o_empty    <= (nextCount == '0);
    end
  end

  // entry updates, none of these touch the same slot on one edge
  always_ff @(posedge clk) begin
    if (accept) begin
      entries[tailPtr] <= allocEntry;
    end
    if (issueFire) begin
      entries[issuePtr].issued <= 1'b1;
    end
    if (mem.rspValid) begin
      entries[mem.rspTag].done <= 1'b1;
      // a store keeps its own write data
      if (!entries[mem.rspTag].isWrite) begin
        entries[mem.rspTag].data <= mem.rspData;
      end
    end
  end

  // retire payload, held until the next retire
  always_ff @(posedge clk) begin
    if (retire) begin
      o_retWrite <= entries[headPtr].isWrite;
      o_retAddr  <= entries[headPtr].addr;
      o_retData  <= entries[headPtr].data;
      o_retDest  <= entries[headPtr].dest;
    end
  end

endmodule

`default_nettype wire

// ==== design/dataMemory.sv ====
// word-addressed data memory with a fast odd path and a slow even path, answers carry the tag
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module dataMemory (
  input  wire       clk,
  input  wire       rst,
  memPortIf.memSide mem
);

  localparam int idxW       = $bits(memPkg::wordIdxT);
  localparam int slowStages = `MEM_SLOW_STAGES;

  // word array
  logic [`DATA_W-1:0] memArray [`MEM_WORDS];

  // slow path delay line, entry 0 is loaded on acceptance
  memPkg::memRspT slowLine [`MEM_SLOW_STAGES];

  // response register, fed by the fast path or by the end of the slow line
  memPkg::memRspT rspReg;

  memPkg::wordIdxT reqIdx;
  logic oddReq;
  logic accept;
  memPkg::memRspT newRsp;

  // byte address to word index
  assign reqIdx = mem.reqAddr[idxW+1:2];
  assign oddReq = reqIdx[0];

  // an odd answer would need the response register on the same edge
  // that the last slow stage moves into it, so refuse it for now
  assign mem.reqReady = !(mem.reqValid && oddReq && slowLine[slowStages-1].valid);

  assign accept = mem.reqValid && mem.reqReady;

  // answer for the request on the port
  // read sees the array before this edge, stores answer with zero
  always_comb begin
    newRsp.valid = 1'b1;
    newRsp.tag   = mem.reqTag;
    if (mem.reqWrite) begin
      newRsp.data = '0;
    end else begin
      newRsp.data = memArray[reqIdx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        memArray[i] <= '0;
      end
      for (int i = 0; i < slowStages; i++) begin
        slowLine[i] <= '0;
      end
      rspReg <= '0;
    end else begin
      // store lands on the accepting edge
      if (accept && mem.reqWrite) begin
        memArray[reqIdx] <= mem.reqData;
      end

      // even index enters the slow line, bubbles otherwise
      if (accept && !oddReq) begin
        slowLine[0] <= newRsp;
      end else begin
        slowLine[0] <= '0;
      end
      // shift every cycle, the line never stalls
      for (int i = 1; i < slowStages; i++) begin
        slowLine[i] <= slowLine[i-1];
      end

      // fast path wins the register only when the slow end is empty
      if (accept && oddReq) begin
        rspReg <= newRsp;
      end else begin
        rspReg <= slowLine[slowStages-1];
      end
    end
  end

  // answer toward the queue
  assign mem.rspValid = rspReg.valid;
  assign mem.rspTag   = rspReg.tag;
  assign mem.rspData  = rspReg.data;

endmodule

`default_nettype wire

// ==== design/lsqMemTop.sv ====
// top level joining the load/store queue to the data memory, plain core-side ports
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module lsqMemTop (
  input  wire                      clk,
  input  wire                      rst,
  // core requests
  input  wire                      i_reqValid,
  input  wire                      i_reqWrite,
  input  wire  [`DATA_W-1:0]       i_reqAddr,
  input  wire  [`DATA_W-1:0]       i_reqData,
  input  wire  lsqPkg::destT       i_reqDest,
  output logic                     o_reqStall,
  output logic                     o_empty,
  // retired entries back to the core
  output logic                     o_retValid,
  output logic                     o_retWrite,
  output logic [`DATA_W-1:0]       o_retAddr,
  output logic [`DATA_W-1:0]       o_retData,
  output lsqPkg::destT             o_retDest
);

  // queue to memory channel
  memPortIf memBus0 ();

  loadStoreQueue lsq0 (
    .clk        (clk),
    .rst        (rst),
    .i_reqValid (i_reqValid),
    .i_reqWrite (i_reqWrite),
    .i_reqAddr  (i_reqAddr),
    .i_reqData  (i_reqData),
    .i_reqDest  (i_reqDest),
    .o_reqStall (o_reqStall),
    .o_empty    (o_empty),
    .o_retValid (o_retValid),
    .o_retWrite (o_retWrite),
    .o_retAddr  (o_retAddr),
    .o_retData  (o_retData),
    .o_retDest  (o_retDest),
    .mem        (memBus0.lsqSide)
  );

  dataMemory mem0 (
    .clk (clk),
    .rst (rst),
    .mem (memBus0.memSide)
  );

endmodule

`default_nettype wire

// ==== test/lsqMemTb.sv ====
// self-checking testbench for lsqMemTop, compiled from the project root through the file list
`timescale 1ns/1ps
`default_nettype none

`include "lsq_config.svh"

module lsqMemTb;

  // wait limits in clock cycles
  localparam int reqTimeout   = 200;
  localparam int retireLimit  = 200;
  localparam int drainTimeout = 400;

  // one accepted request as the model keeps it
  typedef struct packed {
    logic isWrite;
    logic [`DATA_W-1:0] addr;
    // value the retire has to carry
    logic [`DATA_W-1:0] data;
    lsqPkg::destT dest;
    int acceptCycle;
  } reqRecT;

  logic clk = 1'b0;
  logic rst;
  logic i_reqValid;
  logic i_reqWrite;
  logic [`DATA_W-1:0] i_reqAddr;
  logic [`DATA_W-1:0] i_reqData;
  lsqPkg::destT i_reqDest;
  logic o_reqStall;
  logic o_empty;
  logic o_retValid;
  logic o_retWrite;
  logic [`DATA_W-1:0] o_retAddr;
  logic [`DATA_W-1:0] o_retData;
  lsqPkg::destT o_retDest;

  // edge capture of what the DUT took
  logic rstSeen = 1'b1;
  logic acceptSeen = 1'b0;
  logic accWrite;
  logic [`DATA_W-1:0] accAddr;
  logic [`DATA_W-1:0] accData;
  lsqPkg::destT accDest;

  // reference model
  logic [`DATA_W-1:0] shadowMem [`MEM_WORDS];
  reqRecT modelQ [$];
  int modelCount = 0;
  int cycleCnt = 0;
  logic anyAccepted = 1'b0;
  logic fullSeen = 1'b0;

  // values compared on the next rising edge
  logic chkRet = 1'b0;
  logic orphanRet = 1'b0;
  logic overdue = 1'b0;
  logic gotRetValid, gotEmpty, gotStall;
  logic gotWrite, expWrite;
  logic [`DATA_W-1:0] gotAddr, expAddr, gotData, expData;
  lsqPkg::destT gotDest, expDest;

  int valueErrors = 0;
  int protocolErrors = 0;
  int stimErrors = 0;
  logic aborted = 1'b0;
  logic [31:0] lfsrState = 32'hc9611bd3;

  lsqMemTop dut0 (
    .clk        (clk),
    .rst        (rst),
    .i_reqValid (i_reqValid),
    .i_reqWrite (i_reqWrite),
    .i_reqAddr  (i_reqAddr),
    .i_reqData  (i_reqData),
    .i_reqDest  (i_reqDest),
    .o_reqStall (o_reqStall),
    .o_empty    (o_empty),
    .o_retValid (o_retValid),
    .o_retWrite (o_retWrite),
    .o_retAddr  (o_retAddr),
    .o_retData  (o_retData),
    .o_retDest  (o_retDest)
  );

  always #10 clk = ~clk;

  // request and reset as the DUT saw them on this edge
  always @(posedge clk) begin
    rstSeen    <= rst;
    acceptSeen <= !rst && i_reqValid && !o_reqStall;
    accWrite   <= i_reqWrite;
    accAddr    <= i_reqAddr;
    accData    <= i_reqData;
    accDest    <= i_reqDest;
  end

  // model step on the falling edge, outputs are settled here
  always @(negedge clk) begin
    reqRecT rec;
    logic [9:0] idx;
    gotRetValid = o_retValid;
    gotEmpty    = o_empty;
    gotStall    = o_reqStall;
    chkRet      = 1'b0;
    orphanRet   = 1'b0;
    if (rstSeen) begin
      modelQ.delete();
      modelCount  = 0;
      cycleCnt    = 0;
      anyAccepted = 1'b0;
      overdue     = 1'b0;
      for (int i = 0; i < `MEM_WORDS; i++) begin
        shadowMem[i] = '0;
      end
    end else begin
      cycleCnt++;
      // retire first, nothing retires on its own accepting edge
      if (o_retValid) begin
        if (modelQ.size() == 0) begin
          orphanRet = 1'b1;
        end else begin
          rec      = modelQ.pop_front();
          chkRet   = 1'b1;
          expWrite = rec.isWrite;
          expAddr  = rec.addr;
          expData  = rec.data;
          expDest  = rec.dest;
          gotWrite = o_retWrite;
          gotAddr  = o_retAddr;
          gotData  = o_retData;
          gotDest  = o_retDest;
          modelCount--;
        end
      end
      if (acceptSeen) begin
        // word index is address bits 11:2
        idx             = accAddr[11:2];
        rec.isWrite     = accWrite;
        rec.addr        = accAddr;
        rec.dest        = accDest;
        rec.acceptCycle = cycleCnt;
        if (accWrite) begin
          rec.data       = accData;
          shadowMem[idx] = accData;
        end else begin
          rec.data = shadowMem[idx];
        end
        modelQ.push_back(rec);
        modelCount++;
        anyAccepted = 1'b1;
      end
      overdue = (modelQ.size() != 0) && (cycleCnt - modelQ[0].acceptCycle > retireLimit);
      if (gotStall) begin
        fullSeen = 1'b1;
      end
    end
  end

  // retire payload against the oldest accepted request
  retWriteCheck: assert property (@(posedge clk) disable iff (rst)
    !chkRet || gotWrite == expWrite)
    else begin
      $display("[FAIL] o_retWrite got %h expected %h", gotWrite, expWrite);
      valueErrors++;
    end
  retAddrCheck: assert property (@(posedge clk) disable iff (rst)
    !chkRet || gotAddr == expAddr)
    else begin
      $display("[FAIL] o_retAddr got %h expected %h", gotAddr, expAddr);
      valueErrors++;
    end
  retDataCheck: assert property (@(posedge clk) disable iff (rst)
    !chkRet || gotData == expData)
    else begin
      $display("[FAIL] o_retData got %h expected %h", gotData, expData);
      valueErrors++;
    end
  retDestCheck: assert property (@(posedge clk) disable iff (rst)
    !chkRet || gotDest == expDest)
    else begin
      $display("[FAIL] o_retDest got %h expected %h", gotDest, expDest);
      valueErrors++;
    end

  // occupancy flags follow the model count every cycle
  emptyCheck: assert property (@(posedge clk) disable iff (rst)
    gotEmpty == (modelCount == 0))
    else begin
      $display("[FAIL] o_empty got %h expected %h", gotEmpty, modelCount == 0);
      valueErrors++;
    end
  stallCheck: assert property (@(posedge clk) disable iff (rst)
    gotStall == (modelCount == `LSQ_DEPTH))
    else begin
      $display("[FAIL] o_reqStall got %h expected %h", gotStall, modelCount == `LSQ_DEPTH);
      valueErrors++;
    end

  // quiet outputs before the first request
  idleCheck: assert property (@(posedge clk) disable iff (rst)
    anyAccepted || (!gotRetValid && gotEmpty && !gotStall))
    else begin
      $display("outputs left their reset state before any request was accepted");
      protocolErrors++;
    end
  orphanCheck: assert property (@(posedge clk) disable iff (rst) !orphanRet)
    else begin
      $display("a retire arrived while no accepted request was waiting");
      protocolErrors++;
    end
  overdueCheck: assert property (@(posedge clk) disable iff (rst) !overdue)
    else begin
      $display("oldest request has not retired within %0d cycles", retireLimit);
      protocolErrors++;
    end

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrStep()};
    end
    return v;
  endfunction

  // random bits above the index alias onto the same word
  function automatic logic [31:0] wordAddr(input logic [9:0] idx);
    logic [31:0] hi;
    hi = randBits(4);
    return {16'h0000, hi[3:0], idx, 2'b00};
  endfunction

  task automatic idle(input int n);
    i_reqValid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // hold the request until an edge takes it
  task automatic sendReq(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                         input lsqPkg::destT dest);
    int waits;
    if (aborted) return;
    i_reqValid = 1'b1;
    i_reqWrite = wr;
    i_reqAddr  = addr;
    i_reqData  = data;
    i_reqDest  = dest;
    waits = 0;
    @(negedge clk);
    while (!acceptSeen && waits < reqTimeout) begin
      @(negedge clk);
      waits++;
    end
    i_reqValid = 1'b0;
    if (!acceptSeen) begin
      $display("request to address %h was not accepted within %0d cycles", addr, reqTimeout);
      stimErrors++;
      aborted = 1'b1;
    end
  endtask

  // wait on the rising edge, the model count is stable there
  task automatic drain();
    int waits;
    if (aborted) return;
    waits = 0;
    @(posedge clk);
    while (modelCount != 0 && waits < drainTimeout) begin
      @(posedge clk);
      waits++;
    end
    if (modelCount != 0) begin
      $display("queue still held %0d requests after %0d cycles", modelCount, drainTimeout);
      stimErrors++;
      aborted = 1'b1;
    end
    @(negedge clk);
  endtask

  task automatic directedChecks();
    // slow path store and load, then the fast path pair
    sendReq(1'b1, wordAddr(10'h004), 32'hdeadbeef, 4'h1);
    sendReq(1'b0, wordAddr(10'h004), 32'hffffffff, 4'h2);
    sendReq(1'b1, wordAddr(10'h005), 32'h12345678, 4'h3);
    sendReq(1'b0, wordAddr(10'h005), 32'hffffffff, 4'h4);
    // never written words read zero
    sendReq(1'b0, wordAddr(10'h200), 32'hffffffff, 4'h5);
    sendReq(1'b0, wordAddr(10'h201), 32'hffffffff, 4'h6);
    // overwrite then read behind a slow store
    sendReq(1'b1, wordAddr(10'h004), 32'h0badf00d, 4'h7);
    sendReq(1'b0, wordAddr(10'h005), 32'hffffffff, 4'h8);
    sendReq(1'b0, wordAddr(10'h004), 32'hffffffff, 4'h9);
    drain();
  endtask

  task automatic randomMix(input int n);
    logic [31:0] wr;
    logic [31:0] idx;
    logic [31:0] dat;
    logic [31:0] dst;
    logic [31:0] gap;
    for (int i = 0; i < n; i++) begin
      if (aborted) break;
      wr  = randBits(1);
      idx = randBits(5);
      dat = randBits(32);
      dst = randBits(4);
      sendReq(wr[0], wordAddr({5'b00000, idx[4:0]}), dat, dst[3:0]);
      // about one request in four leaves a gap
      gap = randBits(2);
      if (gap[1:0] == 2'b00) begin
        idle(1);
      end
    end
  endtask

  // oddEvery of 4 puts an odd word after three even ones
  task automatic burst(input int n, input int oddEvery);
    logic [31:0] wr;
    logic [31:0] idx;
    logic [31:0] dat;
    logic [31:0] dst;
    logic oddBit;
    for (int i = 0; i < n; i++) begin
      if (aborted) break;
      wr     = randBits(1);
      idx    = randBits(4);
      dat    = randBits(32);
      dst    = randBits(4);
      oddBit = (oddEvery != 0) && ((i % oddEvery) == oddEvery - 1);
      sendReq(wr[0], wordAddr({5'b00000, idx[3:0], oddBit}), dat, dst[3:0]);
    end
  endtask

  initial begin
    rst        = 1'b1;
    i_reqValid = 1'b0;
    i_reqWrite = 1'b0;
    i_reqAddr  = '0;
    i_reqData  = '0;
    i_reqDest  = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    idle(6);
    directedChecks();
    randomMix(200);
    drain();
    // back to back even words
    burst(40, 0);
    drain();
    // refused odd words slow the issue side until the queue fills
    burst(64, 4);
    drain();
    repeat (3) @(posedge clk);
    if (!aborted) begin
      fullCheck: assert (fullSeen)
        else begin
          $display("queue never reported full during the bursts");
          stimErrors++;
        end
    end
    $display("errors: value %0d, protocol %0d, stimulus %0d",
             valueErrors, protocolErrors, stimErrors);
    if (valueErrors == 0 && protocolErrors == 0 && stimErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== lsqMem.f ====
+incdir+design
design/lsqPkg.sv
design/memPkg.sv
design/memPortIf.sv
design/loadStoreQueue.sv
design/dataMemory.sv
design/lsqMemTop.sv
test/lsqMemTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and fails when the log reports a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lsqMem.f --top-module lsqMemTb \
  -Mdir obj_dir -o simv > build.log 2>&1
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  cat build.log
  echo "build failed with status $buildStatus"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
